//--- nibble_core.f
+incdir+tb
hw/nibble_pkg.sv
hw/alu_4bit.sv
hw/nibble_regfile.sv
hw/nibble_pc.sv
hw/nibble_imem.sv
hw/nibble_ctrl.sv
hw/nibble_core.sv
tb/nibble_core_tb.sv

//--- tb/nibble_checks.svh
//****************************************
// nibble core testbench compare tasks
//****************************************

`ifndef NIBBLE_CHECKS_SVH
`define NIBBLE_CHECKS_SVH

task automatic check_reg(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
		input string msg);
	if (got !== exp) begin
		$display("FAIL %0t: %s, got %0d expected %0d", $time, msg, got, exp);
		error_count++;
	end
endtask

// carry, overflow, zero in that order
task automatic check_flags(input logic c, input logic v, input logic z,
		input logic exp_c, input logic exp_v, input logic exp_z, input string msg);
	if ({c, v, z} !== {exp_c, exp_v, exp_z}) begin
		$display("FAIL %0t: %s, flags cvz got %b%b%b expected %b%b%b",
			$time, msg, c, v, z, exp_c, exp_v, exp_z);
		error_count++;
	end
endtask

task automatic check_status(input logic busy_got, input logic halted_got,
		input logic exp_busy, input logic exp_halted, input string msg);
	if ({busy_got, halted_got} !== {exp_busy, exp_halted}) begin
		$display("FAIL %0t: %s, busy/halted got %b/%b expected %b/%b",
			$time, msg, busy_got, halted_got, exp_busy, exp_halted);
		error_count++;
	end
endtask

// clock cycles from the start edge to halted
task automatic check_cycles(input int got, input int exp, input string msg);
	if (got != exp) begin
		$display("FAIL %0t: %s, took %0d cycles expected %0d", $time, msg, got, exp);
		error_count++;
	end
endtask

`endif

//--- tb/nibble_core_tb.sv
//****************************************
// nibble core testbench, ALU table, li, branch loop and control
//****************************************

`timescale 1ns/1ps

module nibble_core_tb import nibble_pkg::*; ();

	typedef struct packed {
		alu_fn_t fn;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] res;
		logic c;
		logic v;
		logic z;
	} alu_row_t;

	localparam int run_timeout = 100;
	localparam int table_rows = 24;
	localparam int random_rows = 16;

	logic clk;
	logic rst_n;
	logic start;
	logic prog_we;
	logic [addr_w-1:0] prog_addr;
	instr_t prog_data;
	logic [reg_sel_w-1:0] dbg_sel;
	logic [data_w-1:0] dbg_data;
	logic busy;
	logic halted;
	logic flag_zero;
	logic flag_carry;
	logic flag_overflow;

	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start;
	int cycles;
	instr_t prog_q[$];
	alu_row_t rows [table_rows + random_rows];

	`include "nibble_checks.svh"

	nibble_core UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.prog_we       (prog_we),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.dbg_sel       (dbg_sel),
		.dbg_data      (dbg_data),
		.busy          (busy),
		.halted        (halted),
		.flag_zero     (flag_zero),
		.flag_carry    (flag_carry),
		.flag_overflow (flag_overflow)
	);

	always #5 clk = ~clk;

	function automatic instr_t make_alu(alu_fn_t fn, logic [reg_sel_w-1:0] rd,
			logic [reg_sel_w-1:0] ra, logic [reg_sel_w-1:0] rb);
		instr_t w;
		w = '0;
		w.alu_form.cls = cls_alu;
		w.alu_form.fn = fn;
		w.alu_form.rd = rd;
		w.alu_form.ra = ra;
		w.alu_form.rb = rb;
		return w;
	endfunction

	// li, bz and halt all use the immediate layout
	function automatic instr_t make_imm(instr_cls_t cls, logic [reg_sel_w-1:0] rd,
			logic [data_w-1:0] imm);
		instr_t w;
		w = '0;
		w.imm_form.cls = cls;
		w.imm_form.rd = rd;
		w.imm_form.imm = imm;
		return w;
	endfunction

	function automatic alu_row_t table_row(alu_fn_t fn, logic [data_w-1:0] a,
			logic [data_w-1:0] b, logic [data_w-1:0] res, logic c, logic v, logic z);
		alu_row_t r;
		r.fn = fn;
		r.a = a;
		r.b = b;
		r.res = res;
		r.c = c;
		r.v = v;
		r.z = z;
		return r;
	endfunction

	// reference model worked out on integers
	function automatic alu_row_t expected_alu(alu_fn_t fn, logic [data_w-1:0] a,
			logic [data_w-1:0] b);
		alu_row_t r;
		int sa;
		int sb;
		int wide;
		r = table_row(fn, a, b, '0, 1'b0, 1'b0, 1'b0);
		sa = $signed(a);
		sb = $signed(b);
		case (fn)
			fn_add: begin
				wide = int'(a) + int'(b);
				r.res = wide[data_w-1:0];
				r.c = (wide > 15);
				r.v = (sa + sb > 7) || (sa + sb < -8);
				r.z = (r.res == 0);
			end
			fn_sub: begin
				wide = int'(a) - int'(b);
				r.res = wide[data_w-1:0];
				// carry set means no borrow
				r.c = (a >= b);
				r.v = (sa - sb > 7) || (sa - sb < -8);
				r.z = (r.res == 0);
			end
			fn_not: r.res = ~a;
			fn_and: r.res = a & b;
			fn_or:  r.res = a | b;
			fn_xor: r.res = a ^ b;
			fn_lt:  r.res = (a < b) ? 1 : 0;
			default: r.res = (a == b) ? 1 : 0;
		endcase
		return r;
	endfunction

	task automatic fill_table();
		rows[0]  = table_row(fn_add, 3, 4, 7, 0, 0, 0);
		rows[1]  = table_row(fn_add, 15, 1, 0, 1, 0, 1);
		rows[2]  = table_row(fn_add, 7, 1, 8, 0, 1, 0);
		rows[3]  = table_row(fn_add, 8, 8, 0, 1, 1, 1);
		rows[4]  = table_row(fn_add, 0, 0, 0, 0, 0, 1);
		rows[5]  = table_row(fn_add, 9, 10, 3, 1, 1, 0);
		rows[6]  = table_row(fn_sub, 5, 3, 2, 1, 0, 0);
		rows[7]  = table_row(fn_sub, 3, 5, 14, 0, 0, 0);
		rows[8]  = table_row(fn_sub, 6, 6, 0, 1, 0, 1);
		rows[9]  = table_row(fn_sub, 8, 1, 7, 1, 1, 0);
		rows[10] = table_row(fn_sub, 0, 1, 15, 0, 0, 0);
		// overflow left set so the first logic row must clear it
		rows[11] = table_row(fn_sub, 7, 15, 8, 0, 1, 0);
		rows[12] = table_row(fn_not, 5, 0, 10, 0, 0, 0);
		rows[13] = table_row(fn_not, 15, 3, 0, 0, 0, 0);
		rows[14] = table_row(fn_and, 12, 10, 8, 0, 0, 0);
		rows[15] = table_row(fn_and, 5, 10, 0, 0, 0, 0);
		rows[16] = table_row(fn_or, 12, 3, 15, 0, 0, 0);
		rows[17] = table_row(fn_or, 0, 0, 0, 0, 0, 0);
		rows[18] = table_row(fn_xor, 15, 10, 5, 0, 0, 0);
		rows[19] = table_row(fn_xor, 6, 6, 0, 0, 0, 0);
		rows[20] = table_row(fn_lt, 3, 9, 1, 0, 0, 0);
		rows[21] = table_row(fn_lt, 9, 3, 0, 0, 0, 0);
		rows[22] = table_row(fn_eq, 7, 7, 1, 0, 0, 0);
		rows[23] = table_row(fn_eq, 7, 8, 0, 0, 0, 0);
		for (int i = table_rows; i < table_rows + random_rows; i++)
			rows[i] = expected_alu(alu_fn_t'($urandom_range(0, 7)),
				$urandom_range(0, 15), $urandom_range(0, 15));
	endtask

	task automatic load_program();
		foreach (prog_q[i]) begin
			prog_we = 1'b1;
			prog_addr = i;
			prog_data = prog_q[i];
			@(posedge clk);
			#1;
		end
		prog_we = 1'b0;
	endtask

	// with disturb set, a second start and a program write land mid-run
	task automatic run_program(input bit disturb);
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		cycles = 0;
		while (!halted && cycles < run_timeout) begin
			@(posedge clk);
			#1;
			cycles++;
			if (disturb && cycles == 2)
				check_status(busy, halted, 1'b1, 1'b0, "status while running");
			start = disturb && (cycles == 4);
			prog_we = disturb && (cycles == 6);
			prog_addr = 3;
			prog_data = make_imm(cls_li, 3, 15);
		end
		start = 1'b0;
		prog_we = 1'b0;
		if (!halted) begin
			$display("core never halted within %0d cycles after start", run_timeout);
			$display("Regression failed");
			$finish;
		end
	endtask

	task automatic read_reg(input logic [reg_sel_w-1:0] r, output logic [data_w-1:0] val);
		dbg_sel = r;
		#1;
		val = dbg_data;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED", name);
			tests_failed++;
		end
	endtask

	task automatic load_count_loop(input logic [data_w-1:0] n);
		prog_q.delete();
		prog_q.push_back(make_imm(cls_li, 0, n));
		prog_q.push_back(make_imm(cls_li, 1, 1));
		prog_q.push_back(make_imm(cls_li, 3, 0));
		prog_q.push_back(make_alu(fn_add, 3, 3, 1));
		prog_q.push_back(make_alu(fn_sub, 0, 0, 1));
		// leave the loop once the counter reaches zero
		prog_q.push_back(make_imm(cls_bz, 0, 8));
		prog_q.push_back(make_alu(fn_sub, 2, 1, 1));
		prog_q.push_back(make_imm(cls_bz, 0, 3));
		prog_q.push_back(make_imm(cls_halt, 0, 0));
		load_program();
	endtask

	initial begin
		logic [data_w-1:0] val;
		logic [data_w-1:0] li_vals [4];
		alu_row_t row;
		int loop_n;
		void'($urandom(32'hc258_4866));
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_sel = '0;
		fill_table();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		errors_at_start = error_count;
		check_status(busy, halted, 1'b0, 1'b0, "status after reset");
		end_test("reset");

		for (int i = 0; i < table_rows + random_rows; i++) begin
			row = rows[i];
			errors_at_start = error_count;
			prog_q.delete();
			prog_q.push_back(make_imm(cls_li, 0, row.a));
			prog_q.push_back(make_imm(cls_li, 1, row.b));
			prog_q.push_back(make_alu(row.fn, 2, 0, 1));
			prog_q.push_back(make_imm(cls_halt, 0, 0));
			load_program();
			run_program(1'b0);
			check_cycles(cycles, 2 * prog_q.size(), "alu program length");
			read_reg(2, val);
			check_reg(val, row.res, $sformatf("r2 for %s %0d,%0d", row.fn.name(), row.a, row.b));
			check_flags(flag_carry, flag_overflow, flag_zero, row.c, row.v, row.z,
				$sformatf("flags for %s %0d,%0d", row.fn.name(), row.a, row.b));
			end_test($sformatf("alu row %0d %s %0d,%0d", i, row.fn.name(), row.a, row.b));
		end

		// 8 + 8 leaves carry, overflow and zero all set before the loads
		errors_at_start = error_count;
		li_vals = '{4'd5, 4'd10, 4'd3, 4'd12};
		prog_q.delete();
		prog_q.push_back(make_imm(cls_li, 0, 8));
		prog_q.push_back(make_imm(cls_li, 1, 8));
		prog_q.push_back(make_alu(fn_add, 3, 0, 1));
		for (int r = 0; r < 4; r++)
			prog_q.push_back(make_imm(cls_li, r, li_vals[r]));
		prog_q.push_back(make_imm(cls_halt, 0, 0));
		load_program();
		run_program(1'b0);
		for (int r = 0; r < 4; r++) begin
			read_reg(r, val);
			check_reg(val, li_vals[r], $sformatf("li into r%0d", r));
		end
		check_flags(flag_carry, flag_overflow, flag_zero, 1'b1, 1'b1, 1'b1, "flags after li");
		end_test("load immediate");

		// each pass runs add, sub, bz and then sub, bz back except the last
		loop_n = 5;
		errors_at_start = error_count;
		load_count_loop(loop_n);
		run_program(1'b0);
		check_cycles(cycles, 2 * (3 + 5 * (loop_n - 1) + 4), "count loop length");
		read_reg(3, val);
		check_reg(val, loop_n, "loop count in r3");
		read_reg(0, val);
		check_reg(val, 0, "loop counter in r0");
		check_flags(flag_carry, flag_overflow, flag_zero, 1'b1, 1'b0, 1'b1, "flags after loop");
		end_test("branch loop");

		errors_at_start = error_count;
		run_program(1'b1);
		check_cycles(cycles, 2 * (3 + 5 * (loop_n - 1) + 4), "loop length with restart");
		read_reg(3, val);
		check_reg(val, loop_n, "loop count after write while busy");
		check_status(busy, halted, 1'b0, 1'b1, "status after halt");
		end_test("control while busy");

		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- hw/nibble_core.sv
//****************************************
// nibble core top, memory, pc, controller, registers and ALU
//****************************************

`timescale 1ns/1ps

module nibble_core import nibble_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  prog_we,
	input  logic [addr_w-1:0]     prog_addr,
	input  instr_t                prog_data,
	input  logic [reg_sel_w-1:0]  dbg_sel,
	output logic [data_w-1:0]     dbg_data,
	output logic                  busy,
	output logic                  halted,
	output logic                  flag_zero,
	output logic                  flag_carry,
	output logic                  flag_overflow
);

	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] pc_target;
	logic pc_clear;
	logic pc_step;
	logic pc_load;
	instr_t instr;
	logic mem_lock;
	logic mem_we;

	logic rf_we;
	logic wr_src_imm;
	logic [reg_sel_w-1:0] rd_sel;
	logic [reg_sel_w-1:0] ra_sel;
	logic [reg_sel_w-1:0] rb_sel;
	logic [data_w-1:0] imm;
	logic [data_w-1:0] ra_data;
	logic [data_w-1:0] rb_data;

	alu_fn_t alu_fn;
	logic [data_w-1:0] alu_res;
	logic alu_zero;
	logic alu_carry;
	logic alu_overflow;

	// program loads are dropped while a program runs
	assign mem_we = prog_we & ~mem_lock;

	nibble_imem u_imem (
		.clk   (clk),
		.we    (mem_we),
		.waddr (prog_addr),
		.wdata (prog_data),
		.raddr (pc),
		.rdata (instr)
	);

	nibble_pc u_pc (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (pc_clear),
		.step   (pc_step),
		.load   (pc_load),
		.target (pc_target),
		.pc     (pc)
	);

	nibble_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.instr         (instr),
		.alu_zero      (alu_zero),
		.alu_carry     (alu_carry),
		.alu_overflow  (alu_overflow),
		.pc_clear      (pc_clear),
		.pc_step       (pc_step),
		.pc_load       (pc_load),
		.pc_target     (pc_target),
		.rf_we         (rf_we),
		.wr_src_imm    (wr_src_imm),
		.rd_sel        (rd_sel),
		.ra_sel        (ra_sel),
		.rb_sel        (rb_sel),
		.imm           (imm),
		.alu_fn        (alu_fn),
		.busy          (busy),
		.halted        (halted),
		.flag_zero     (flag_zero),
		.flag_carry    (flag_carry),
		.flag_overflow (flag_overflow),
		.mem_lock      (mem_lock)
	);

	nibble_regfile u_regfile (
		.clk        (clk),
		.rst_n      (rst_n),
		.we         (rf_we),
		.rd_sel     (rd_sel),
		.ra_sel     (ra_sel),
		.rb_sel     (rb_sel),
		.dbg_sel    (dbg_sel),
		.alu_res    (alu_res),
		.imm        (imm),
		.wr_src_imm (wr_src_imm),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.dbg_data   (dbg_data)
	);

	alu_4bit u_alu (
		.alu_fnselec  (alu_fn),
		.alu_a        (ra_data),
		.alu_b        (rb_data),
		.alu_res      (alu_res),
		.alu_zero     (alu_zero),
		.alu_overflow (alu_overflow),
		.alu_carry    (alu_carry)
	);

endmodule

//--- hw/nibble_ctrl.sv
//****************************************
// nibble core controller, fetch/exec FSM, decode and flags
//****************************************

`timescale 1ns/1ps

module nibble_ctrl import nibble_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  instr_t                instr,
	input  logic                  alu_zero,
	input  logic                  alu_carry,
	input  logic                  alu_overflow,
	output logic                  pc_clear,
	output logic                  pc_step,
	output logic                  pc_load,
	output logic [addr_w-1:0]     pc_target,
	output logic                  rf_we,
	output logic                  wr_src_imm,
	output logic [reg_sel_w-1:0]  rd_sel,
	output logic [reg_sel_w-1:0]  ra_sel,
	output logic [reg_sel_w-1:0]  rb_sel,
	output logic [data_w-1:0]     imm,
	output alu_fn_t               alu_fn,
	output logic                  busy,
	output logic                  halted,
	output logic                  flag_zero,
	output logic                  flag_carry,
	output logic                  flag_overflow,
	output logic                  mem_lock
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	instr_cls_t cls;
	logic in_exec;
	logic can_start;

	// class bits are common to both forms
	assign cls = instr.alu_form.cls;
	assign in_exec = (state == st_exec);
	assign can_start = (state == st_idle) || (state == st_halt);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle, st_halt: if (start) state_nxt = st_fetch;
			st_fetch: state_nxt = st_exec;
			st_exec: state_nxt = (cls == cls_halt) ? st_halt : st_fetch;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	// rd sits at a different position in each form
	assign rd_sel = (cls == cls_alu) ? instr.alu_form.rd : instr.imm_form.rd;
	assign ra_sel = instr.alu_form.ra;
	assign rb_sel = instr.alu_form.rb;
	assign alu_fn = instr.alu_form.fn;
	assign imm = instr.imm_form.imm;
	assign wr_src_imm = (cls == cls_li);

	assign rf_we = in_exec && ((cls == cls_alu) || (cls == cls_li));

	// branch looks at the latched zero flag, not the live one
	assign pc_clear = can_start && start;
	assign pc_load = in_exec && (cls == cls_bz) && flag_zero;
	assign pc_step = in_exec && !pc_load && (cls != cls_halt);
	assign pc_target = instr.imm_form.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag_zero <= 1'b0;
			flag_carry <= 1'b0;
			flag_overflow <= 1'b0;
		end else if (in_exec && (cls == cls_alu)) begin
			flag_zero <= alu_zero;
			flag_carry <= alu_carry;
			flag_overflow <= alu_overflow;
		end
	end

	assign busy = (state == st_fetch) || in_exec;
	assign halted = (state == st_halt);
	assign mem_lock = busy;

endmodule

//--- hw/nibble_imem.sv
//****************************************
// 16-word program memory, registered read
//****************************************

`timescale 1ns/1ps

module nibble_imem import nibble_pkg::*; (
	input  logic               clk,
	input  logic               we,
	input  logic [addr_w-1:0]  waddr,
	input  instr_t             wdata,
	input  logic [addr_w-1:0]  raddr,
	output instr_t             rdata
);

	instr_t mem [2**addr_w];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// word at raddr shows up one cycle later
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- hw/nibble_pc.sv
//****************************************
// program counter, clear / branch load / step
//****************************************

`timescale 1ns/1ps

module nibble_pc import nibble_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               clear,
	input  logic               step,
	input  logic               load,
	input  logic [addr_w-1:0]  target,
	output logic [addr_w-1:0]  pc
);

	// clear wins over load, load over step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (clear)
			pc <= '0;
		else if (load)
			pc <= target;
		else if (step)
			pc <= pc + 1'b1;
	end

endmodule

//--- hw/nibble_regfile.sv
//****************************************
// four-entry register file, two operand ports and debug port
//****************************************

`timescale 1ns/1ps

module nibble_regfile import nibble_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  we,
	input  logic [reg_sel_w-1:0]  rd_sel,
	input  logic [reg_sel_w-1:0]  ra_sel,
	input  logic [reg_sel_w-1:0]  rb_sel,
	input  logic [reg_sel_w-1:0]  dbg_sel,
	input  logic [data_w-1:0]     alu_res,
	input  logic [data_w-1:0]     imm,
	input  logic                  wr_src_imm,
	output logic [data_w-1:0]     ra_data,
	output logic [data_w-1:0]     rb_data,
	output logic [data_w-1:0]     dbg_data
);

	logic [data_w-1:0] regs [2**reg_sel_w];
	logic [data_w-1:0] wr_data;

	// li writes the immediate, alu ops the result
	assign wr_data = wr_src_imm ? imm : alu_res;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_sel_w; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rd_sel] <= wr_data;
		end
	end

	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];
	assign dbg_data = regs[dbg_sel];

endmodule

//--- hw/alu_4bit.sv
//****************************************
// 4-bit ALU, eight functions with carry, overflow and zero
//****************************************

`timescale 1ns/1ps

module alu_4bit import nibble_pkg::*; (
	input  alu_fn_t            alu_fnselec,
	input  logic [data_w-1:0]  alu_a,
	input  logic [data_w-1:0]  alu_b,
	output logic [data_w-1:0]  alu_res,
	output logic               alu_zero,
	output logic               alu_overflow,
	output logic               alu_carry
);

	logic [data_w:0] sum_add;
	logic [data_w:0] sum_sub;

	assign sum_add = {1'b0, alu_a} + {1'b0, alu_b};
	// carry out of a + ~b + 1 is the inverted borrow
	assign sum_sub = {1'b0, alu_a} + {1'b0, ~alu_b} + {{data_w{1'b0}}, 1'b1};

	always_comb begin
		alu_res = '0;
		alu_carry = 1'b0;
		alu_overflow = 1'b0;
		alu_zero = 1'b0;
		case (alu_fnselec)
			fn_add: begin
				{alu_carry, alu_res} = sum_add;
				alu_overflow = (alu_a[data_w-1] == alu_b[data_w-1]) &&
					(sum_add[data_w-1] != alu_a[data_w-1]);
				alu_zero = (sum_add[data_w-1:0] == '0);
			end
			fn_sub: begin
				{alu_carry, alu_res} = sum_sub;
				// overflow only possible when operand signs differ
				alu_overflow = (alu_a[data_w-1] != alu_b[data_w-1]) &&
					(sum_sub[data_w-1] != alu_a[data_w-1]);
				alu_zero = (sum_sub[data_w-1:0] == '0);
			end
			fn_not: alu_res = ~alu_a;
			fn_and: alu_res = alu_a & alu_b;
			fn_or:  alu_res = alu_a | alu_b;
			fn_xor: alu_res = alu_a ^ alu_b;
			// unsigned comparisons give 1 or 0
			fn_lt:  alu_res = {{(data_w-1){1'b0}}, alu_a < alu_b};
			fn_eq:  alu_res = {{(data_w-1){1'b0}}, alu_a == alu_b};
			default: alu_res = '0;
		endcase
	end

endmodule

//--- hw/nibble_pkg.sv
//****************************************
// nibble core shared widths, encodings and instruction word
//****************************************

package nibble_pkg;

	localparam int data_w = 4;
	localparam int addr_w = 4;
	localparam int reg_sel_w = 2;
	localparam int instr_w = 12;

	// ALU function select codes
	typedef enum logic [2:0] {
		fn_add = 3'b000,
		fn_sub = 3'b001,
		fn_not = 3'b010,
		fn_and = 3'b011,
		fn_or  = 3'b100,
		fn_xor = 3'b101,
		fn_lt  = 3'b110,
		fn_eq  = 3'b111
	} alu_fn_t;

	typedef enum logic [1:0] {
		cls_alu  = 2'b00,
		cls_li   = 2'b01,
		cls_bz   = 2'b10,
		cls_halt = 2'b11
	} instr_cls_t;

	// class field sits in the top two bits of both forms
	typedef union packed {
		struct packed {
			instr_cls_t cls;
			alu_fn_t fn;
			logic [reg_sel_w-1:0] rd;
			logic [reg_sel_w-1:0] ra;
			logic [reg_sel_w-1:0] rb;
			logic [instr_w-$bits(instr_cls_t)-$bits(alu_fn_t)-3*reg_sel_w-1:0] spare;
		} alu_form;
		struct packed {
			instr_cls_t cls;
			logic [reg_sel_w-1:0] rd;
			logic [instr_w-$bits(instr_cls_t)-reg_sel_w-data_w-1:0] spare;
			logic [data_w-1:0] imm;
		} imm_form;
	} instr_t;

	typedef enum logic [1:0] {
		st_idle  = 2'b00,
		st_fetch = 2'b01,
		st_exec  = 2'b10,
		st_halt  = 2'b11
	} ctrl_state_t;

endpackage
